// File: Bender.yml
package:
  name: lsq

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/lsq_pkg.sv
      - verilog/lsq_field_ram.sv
      - verilog/lsq_decode.sv
      - verilog/lsq_execute.sv
      - verilog/lsq_result.sv
      - verilog/lsq_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/lsq_checker.sv
      - dv/lsq_tb.sv

// File: dv/lsq_checker.sv
// protocol assertions for the load/store queue
// bound into the queue top level to watch its strobes
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_checker (
	input logic                  clk,
	input logic                  arst_n_i,
	input logic                  enq_valid_i,
	input logic                  full_i,
	input logic                  commit_i,
	input lsq_pkg::index_t       head_i,
	input logic [`LSQ_DEPTH-1:0] occupied_i,
	input lsq_pkg::ls_op_e       op_table_i [`LSQ_DEPTH],
	input logic [`LSQ_DEPTH-1:0] addr_valid_i,
	input logic [`LSQ_DEPTH-1:0] data_ready_i,
	input logic                  mem_load_en_i,
	input logic                  mem_load_valid_i,
	input logic                  mem_store_en_i,
	input logic                  flush_valid_i,
	input lsq_pkg::index_t       flush_entry_i
);

	int unsigned fail_count = 0;
	logic head_is_store;
	logic head_ready;

	assign head_is_store = op_table_i[head_i] inside {lsq_pkg::SB, lsq_pkg::SH, lsq_pkg::SW};
	// stores wait for the address and loads for the reply
	assign head_ready = occupied_i[head_i] &&
		(head_is_store ? addr_valid_i[head_i] : data_ready_i[head_i]);

	no_enq_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		enq_valid_i |-> !full_i)
		else begin
			$error("enqueue while the queue is full");
			fail_count++;
		end

	commit_needs_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
		commit_i |-> head_ready)
		else begin
			$error("commit while the head entry is not ready");
			fail_count++;
		end

	reply_follows_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_load_valid_i == $past(mem_load_en_i))
		else begin
			$error("memory reply not exactly one cycle after the load issue");
			fail_count++;
		end

	// flushed entry is a live one younger than the head
	flush_with_store: assert property (@(posedge clk) disable iff (!arst_n_i)
		flush_valid_i |-> mem_store_en_i && occupied_i[flush_entry_i] && flush_entry_i != head_i)
		else begin
			$error("flush raised without a committing store or on a dead entry");
			fail_count++;
		end

endmodule

bind lsq_top lsq_checker i_checker (
	.clk             (clk),
	.arst_n_i        (arst_n_i),
	.enq_valid_i     (enq_valid_i),
	.full_i          (full_o),
	.commit_i        (commit_i),
	.head_i          (head),
	.occupied_i      (occupied),
	.op_table_i      (op_table),
	.addr_valid_i    (addr_valid),
	.data_ready_i    (data_ready),
	.mem_load_en_i   (mem_load_en_o),
	.mem_load_valid_i(mem_load_valid_i),
	.mem_store_en_i  (mem_store_en_o),
	.flush_valid_i   (flush_valid_o),
	.flush_entry_i   (flush_entry_o)
);

// File: dv/lsq_tb.sv
// directed testbench for the load/store queue
// one-cycle sparse memory, reference queue model and typed compare tasks
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_tb;

	logic clk;
	logic arst_n_i;
	logic enq_valid_i;
	logic full_o;
	logic exe_valid_i;
	logic commit_i;
	logic mem_load_en_o;
	logic mem_load_valid_i;
	logic mem_store_en_o;
	logic load_valid_o;
	logic flush_valid_o;
	lsq_pkg::ls_op_e enq_op_i;
	lsq_pkg::index_t enq_entry_o;
	lsq_pkg::index_t exe_entry_i;
	lsq_pkg::index_t flush_entry_o;
	lsq_pkg::addr_t exe_addr_i;
	lsq_pkg::addr_t mem_load_addr_o;
	lsq_pkg::addr_t mem_store_addr_o;
	lsq_pkg::word_t exe_data_i;
	lsq_pkg::word_t mem_load_value_i;
	lsq_pkg::word_t mem_store_data_o;
	lsq_pkg::word_t load_data_o;
	lsq_pkg::ls_size_e mem_load_size_o;
	lsq_pkg::ls_size_e mem_store_size_o;

	// sparse byte memory and the reference queue
	logic [7:0] mem_bytes [lsq_pkg::addr_t];
	lsq_pkg::ls_op_e ref_op [`LSQ_DEPTH];
	lsq_pkg::addr_t ref_addr [`LSQ_DEPTH];
	lsq_pkg::word_t ref_data [`LSQ_DEPTH];
	logic ref_exec [`LSQ_DEPTH];
	lsq_pkg::index_t ref_head;
	lsq_pkg::index_t ref_tail;
	int ref_count;
	logic [31:0] rng_state = 32'h58e6_c0a0;
	lsq_pkg::ls_op_e kinds [6] = '{lsq_pkg::LB, lsq_pkg::LH, lsq_pkg::LW,
		lsq_pkg::SB, lsq_pkg::SH, lsq_pkg::SW};

	lsq_top i_dut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic int kind_bytes(lsq_pkg::ls_op_e op);
		case (op)
			lsq_pkg::LB, lsq_pkg::SB: return 1;
			lsq_pkg::LH, lsq_pkg::SH: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic lsq_pkg::ls_size_e kind_size(lsq_pkg::ls_op_e op);
		case (kind_bytes(op))
			1: return lsq_pkg::SIZE_BYTE;
			2: return lsq_pkg::SIZE_HALF;
			default: return lsq_pkg::SIZE_WORD;
		endcase
	endfunction

	function automatic logic is_store(lsq_pkg::ls_op_e op);
		return op inside {lsq_pkg::SB, lsq_pkg::SH, lsq_pkg::SW};
	endfunction

	// little endian read, right-aligned with unwritten bytes hashed from the address
	function automatic lsq_pkg::word_t mem_read(lsq_pkg::addr_t a, int n);
		lsq_pkg::word_t v;
		lsq_pkg::addr_t h;
		v = '0;
		for (int k = 0; k < n; k++) begin
			h = (a + k) * 32'h9e37_79b9;
			v[8 * k +: 8] = mem_bytes.exists(a + k) ? mem_bytes[a + k] : h[31:24];
		end
		return v;
	endfunction

	always @(posedge clk) begin
		mem_load_valid_i <= mem_load_en_o;
		if (mem_load_en_o) begin
			mem_load_value_i <= mem_read(mem_load_addr_o, 1 << mem_load_size_o);
		end
		if (mem_store_en_o) begin
			for (int k = 0; k < (1 << mem_store_size_o); k++) begin
				mem_bytes[mem_store_addr_o + k] = mem_store_data_o[8 * k +: 8];
			end
		end
	end

	task automatic stop_on_failure();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	always @(negedge clk) begin
		if (i_dut.i_checker.fail_count != 0) begin
			$display("a protocol assertion on the queue failed");
			stop_on_failure();
		end
	end

	task automatic check_entry(string name, lsq_pkg::index_t exp, lsq_pkg::index_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_word(string name, lsq_pkg::word_t exp, lsq_pkg::word_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(string name, lsq_pkg::addr_t exp, lsq_pkg::addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_size(string name, lsq_pkg::ls_size_e exp, lsq_pkg::ls_size_e act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	// oldest younger executed load whose bytes meet the head store's bytes
	function automatic logic find_violation(output lsq_pkg::index_t hit);
		lsq_pkg::index_t idx;
		longint s_lo;
		longint l_lo;
		s_lo = longint'(ref_addr[ref_head]);
		hit = '0;
		for (int k = 1; k < ref_count; k++) begin
			idx = ref_head + lsq_pkg::index_t'(k);
			l_lo = longint'(ref_addr[idx]);
			if (ref_exec[idx] && !is_store(ref_op[idx]) &&
				l_lo < s_lo + kind_bytes(ref_op[ref_head]) &&
				s_lo < l_lo + kind_bytes(ref_op[idx])) begin
				hit = idx;
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic enqueue(lsq_pkg::ls_op_e op);
		@(posedge clk);
		enq_valid_i <= 1'b1;
		enq_op_i <= op;
		@(negedge clk);
		check_bit("full_o", 1'b0, full_o);
		check_entry("enq_entry_o", ref_tail, enq_entry_o);
		@(posedge clk);
		enq_valid_i <= 1'b0;
		ref_op[ref_tail] = op;
		ref_exec[ref_tail] = 1'b0;
		ref_tail++;
		ref_count++;
	endtask

	task automatic execute(lsq_pkg::index_t idx, lsq_pkg::addr_t addr, lsq_pkg::word_t data);
		int waited;
		@(posedge clk);
		exe_valid_i <= 1'b1;
		exe_entry_i <= idx;
		exe_addr_i <= addr;
		exe_data_i <= data;
		@(negedge clk);
		check_bit("mem_load_en_o", !is_store(ref_op[idx]), mem_load_en_o);
		ref_addr[idx] = addr;
		ref_data[idx] = is_store(ref_op[idx]) ? data : mem_read(addr, kind_bytes(ref_op[idx]));
		if (!is_store(ref_op[idx])) begin
			check_addr("mem_load_addr_o", addr, mem_load_addr_o);
			check_size("mem_load_size_o", kind_size(ref_op[idx]), mem_load_size_o);
		end
		@(posedge clk);
		exe_valid_i <= 1'b0;
		ref_exec[idx] = 1'b1;
		waited = 0;
		while (!is_store(ref_op[idx]) && !mem_load_valid_i) begin
			if (waited == 4) begin
				$display("no memory reply arrived for the load in entry %0d", idx);
				stop_on_failure();
			end
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic commit_head();
		lsq_pkg::ls_op_e op;
		lsq_pkg::index_t hit;
		logic flush;
		op = ref_op[ref_head];
		flush = 1'b0;
		hit = '0;
		if (is_store(op)) begin
			flush = find_violation(hit);
		end
		@(posedge clk);
		commit_i <= 1'b1;
		@(negedge clk);
		check_bit("load_valid_o", !is_store(op), load_valid_o);
		check_bit("mem_store_en_o", is_store(op), mem_store_en_o);
		check_bit("flush_valid_o", flush, flush_valid_o);
		if (is_store(op)) begin
			check_addr("mem_store_addr_o", ref_addr[ref_head], mem_store_addr_o);
			check_size("mem_store_size_o", kind_size(op), mem_store_size_o);
			check_word("mem_store_data_o", ref_data[ref_head], mem_store_data_o);
		end else begin
			check_word("load_data_o", ref_data[ref_head], load_data_o);
		end
		if (flush) begin
			check_entry("flush_entry_o", hit, flush_entry_o);
		end
		@(posedge clk);
		commit_i <= 1'b0;
		ref_head++;
		ref_count--;
		if (flush) begin
			for (lsq_pkg::index_t i = hit; i != ref_tail; i++) begin
				ref_exec[i] = 1'b0;
			end
			ref_tail = hit;
			ref_count = int'(lsq_pkg::index_t'(hit - ref_head));
		end
	endtask

	task automatic drain();
		while (ref_count > 0) begin
			commit_head();
		end
	endtask

	task automatic reset_values();
		@(negedge clk);
		check_bit("mem_load_en_o", 1'b0, mem_load_en_o);
		check_bit("mem_store_en_o", 1'b0, mem_store_en_o);
		check_bit("load_valid_o", 1'b0, load_valid_o);
		check_bit("flush_valid_o", 1'b0, flush_valid_o);
		check_bit("full_o", 1'b0, full_o);
		check_entry("enq_entry_o", '0, enq_entry_o);
	endtask

	task automatic load_path();
		lsq_pkg::index_t first;
		first = ref_tail;
		enqueue(lsq_pkg::LB);
		enqueue(lsq_pkg::LH);
		enqueue(lsq_pkg::LW);
		execute(first, 32'h0000_1003, next_rand());
		execute(lsq_pkg::index_t'(first + 1), 32'h0000_1102, next_rand());
		execute(lsq_pkg::index_t'(first + 2), 32'h0000_1200, next_rand());
		drain();
	endtask

	task automatic store_path();
		lsq_pkg::index_t first;
		first = ref_tail;
		enqueue(lsq_pkg::SB);
		enqueue(lsq_pkg::SH);
		enqueue(lsq_pkg::SW);
		execute(first, 32'h0000_2000, 32'ha1b2_c3d4);
		execute(lsq_pkg::index_t'(first + 1), 32'h0000_2010, 32'h5566_7788);
		execute(lsq_pkg::index_t'(first + 2), 32'h0000_2020, 32'h0bad_f00d);
		drain();
		first = ref_tail;
		enqueue(lsq_pkg::LB);
		enqueue(lsq_pkg::LH);
		enqueue(lsq_pkg::LW);
		execute(first, 32'h0000_2000, '0);
		execute(lsq_pkg::index_t'(first + 1), 32'h0000_2010, '0);
		execute(lsq_pkg::index_t'(first + 2), 32'h0000_2020, '0);
		// only the stored bytes come back
		check_word("LB read back", 32'h0000_00d4, ref_data[first]);
		check_word("LH read back", 32'h0000_7788, ref_data[lsq_pkg::index_t'(first + 1)]);
		check_word("LW read back", 32'h0bad_f00d, ref_data[lsq_pkg::index_t'(first + 2)]);
		drain();
	endtask

	task automatic overlap_flush();
		lsq_pkg::index_t first;
		first = ref_tail;
		enqueue(lsq_pkg::SW);
		enqueue(lsq_pkg::LB);
		enqueue(lsq_pkg::LH);
		enqueue(lsq_pkg::LW);
		enqueue(lsq_pkg::LB);
		execute(first, 32'h0000_3000, next_rand());
		execute(lsq_pkg::index_t'(first + 1), 32'h0000_3010, '0);
		execute(lsq_pkg::index_t'(first + 2), 32'h0000_3002, '0);
		execute(lsq_pkg::index_t'(first + 3), 32'h0000_2ffe, '0);
		execute(lsq_pkg::index_t'(first + 4), 32'h0000_3001, '0);
		commit_head();
		@(negedge clk);
		// the LH at first+2 is the oldest overlap and takes the tail back
		check_entry("enq_entry_o", lsq_pkg::index_t'(first + 2), enq_entry_o);
		drain();
		first = ref_tail;
		enqueue(lsq_pkg::SH);
		enqueue(lsq_pkg::LB);
		enqueue(lsq_pkg::LW);
		enqueue(lsq_pkg::LH);
		execute(first, 32'h0000_3100, next_rand());
		execute(lsq_pkg::index_t'(first + 1), 32'h0000_3102, '0);
		execute(lsq_pkg::index_t'(first + 2), 32'h0000_30fc, '0);
		execute(lsq_pkg::index_t'(first + 3), 32'h0000_3104, '0);
		drain();
	endtask

	task automatic capacity_wrap();
		lsq_pkg::index_t first;
		first = ref_tail;
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			enqueue(lsq_pkg::SW);
		end
		@(negedge clk);
		check_bit("full_o", 1'b1, full_o);
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			execute(lsq_pkg::index_t'(first + i), 32'h0000_4000 + 4 * i, next_rand());
		end
		commit_head();
		@(negedge clk);
		check_bit("full_o", 1'b0, full_o);
		check_entry("enq_entry_o", first, enq_entry_o);
		enqueue(lsq_pkg::SB);
		execute(first, 32'h0000_4100, next_rand());
		drain();
	endtask

	task automatic random_mix();
		lsq_pkg::index_t first;
		int n;
		for (int round = 0; round < 12; round++) begin
			first = ref_tail;
			n = 2 + int'(next_rand() % 7);
			for (int i = 0; i < n; i++) begin
				enqueue(kinds[next_rand() % 6]);
			end
			for (int i = 0; i < n; i++) begin
				execute(lsq_pkg::index_t'(first + i), 32'h0000_5000 + (next_rand() & 32'hf),
					next_rand());
			end
			drain();
		end
	endtask

	initial begin
		arst_n_i = 1'b0;
		enq_valid_i = 1'b0;
		enq_op_i = lsq_pkg::LB;
		exe_valid_i = 1'b0;
		exe_entry_i = '0;
		exe_addr_i = '0;
		exe_data_i = '0;
		mem_load_valid_i = 1'b0;
		mem_load_value_i = '0;
		commit_i = 1'b0;
		ref_head = '0;
		ref_tail = '0;
		ref_count = 0;
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			ref_exec[i] = 1'b0;
		end
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;
		reset_values();
		load_path();
		store_path();
		overlap_flush();
		capacity_wrap();
		random_mix();
		@(negedge clk);
		if (i_dut.i_checker.fail_count != 0) begin
			$display("a protocol assertion on the queue failed");
			stop_on_failure();
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: include/lsq_macros.svh
// load/store queue sizing constants
// shared by the RTL and the testbench
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// number of queue entries, a power of two
`define LSQ_DEPTH 32

// bits of an entry number, log2 of the depth
`define LSQ_INDEX_W 5

// address and data word width
`define LSQ_OPRAND_W 32

// one memory byte lane
`define LSQ_BYTE_W 8

`endif

// File: tb.f
+incdir+include
verilog/lsq_pkg.sv
verilog/lsq_field_ram.sv
verilog/lsq_decode.sv
verilog/lsq_execute.sv
verilog/lsq_result.sv
verilog/lsq_top.sv
dv/lsq_checker.sv
dv/lsq_tb.sv

// File: verilog/lsq_decode.sv
// dispatch side of the load/store queue
// allocates entries at the tail, tracks head, occupancy and full,
// and rolls the tail back on an order-violation flush
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_decode (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  enq_valid_i,
	input  lsq_pkg::ls_op_e       enq_op_i,
	input  logic                  commit_adv_i,
	input  logic                  flush_valid_i,
	input  lsq_pkg::index_t       flush_entry_i,
	output lsq_pkg::index_t       enq_entry_o,
	output logic                  full_o,
	output lsq_pkg::index_t       head_o,
	output lsq_pkg::index_t       tail_o,
	output logic [`LSQ_DEPTH-1:0] occupied_o,
	output lsq_pkg::ls_op_e       op_table_o [`LSQ_DEPTH]
);

	lsq_pkg::index_t head_q;
	lsq_pkg::index_t tail_q;
	logic [`LSQ_INDEX_W:0] count_q;
	logic [`LSQ_DEPTH-1:0] occupied_q;
	logic enq_accept;

	// an enqueue in the flush cycle is younger than the flushed load, drop it
	assign enq_accept = enq_valid_i && !flush_valid_i;

	lsq_field_ram #(
		.payload_t(lsq_pkg::ls_op_e)
	) i_op_ram (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.wr_en_i  (enq_accept),
		.wr_idx_i (tail_q),
		.wr_data_i(enq_op_i),
		.entries_o(op_table_o)
	);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (commit_adv_i) begin
				head_q <= head_q + 1'b1;
			end
			if (flush_valid_i) begin
				tail_q <= flush_entry_i;
				// survivors run from the new head up to the flushed entry
				count_q <= {1'b0, lsq_pkg::index_t'(flush_entry_i - head_q
					- lsq_pkg::index_t'(commit_adv_i))};
			end else begin
				if (enq_accept) begin
					tail_q <= tail_q + 1'b1;
				end
				count_q <= count_q + enq_accept - commit_adv_i;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			occupied_q <= '0;
		end else begin
			for (int i = 0; i < `LSQ_DEPTH; i++) begin
				if (flush_valid_i &&
					lsq_pkg::in_flush_range(lsq_pkg::index_t'(i), flush_entry_i, tail_q)) begin
					occupied_q[i] <= 1'b0;
				end else if (commit_adv_i && head_q == lsq_pkg::index_t'(i)) begin
					occupied_q[i] <= 1'b0;
				end else if (enq_accept && tail_q == lsq_pkg::index_t'(i)) begin
					occupied_q[i] <= 1'b1;
				end
			end
		end
	end

	assign enq_entry_o = tail_q;
	assign full_o = (count_q == `LSQ_DEPTH);
	assign head_o = head_q;
	assign tail_o = tail_q;
	assign occupied_o = occupied_q;

endmodule

// File: verilog/lsq_execute.sv
// execute side of the load/store queue
// stores address and data from the address unit, issues loads to memory
// at once and captures the reply a cycle later
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_execute (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  exe_valid_i,
	input  lsq_pkg::index_t       exe_entry_i,
	input  lsq_pkg::addr_t        exe_addr_i,
	input  lsq_pkg::word_t        exe_data_i,
	input  lsq_pkg::ls_op_e       op_table_i [`LSQ_DEPTH],
	input  logic [`LSQ_DEPTH-1:0] occupied_i,
	input  logic                  mem_load_valid_i,
	input  lsq_pkg::word_t        mem_load_value_i,
	input  logic                  flush_valid_i,
	input  lsq_pkg::index_t       flush_entry_i,
	input  lsq_pkg::index_t       tail_i,
	output logic                  mem_load_en_o,
	output lsq_pkg::addr_t        mem_load_addr_o,
	output lsq_pkg::ls_size_e     mem_load_size_o,
	output lsq_pkg::addr_t        addr_table_o [`LSQ_DEPTH],
	output lsq_pkg::word_t        data_table_o [`LSQ_DEPTH],
	output logic [`LSQ_DEPTH-1:0] addr_valid_o,
	output logic [`LSQ_DEPTH-1:0] data_ready_o
);

	lsq_pkg::ls_op_e exe_op;
	logic exe_store;
	logic stage_store_q;
	lsq_pkg::index_t stage_idx_q;
	lsq_pkg::word_t stage_data_q;
	logic data_wr_en;
	lsq_pkg::word_t data_wr_val;
	lsq_pkg::word_t data_ram [`LSQ_DEPTH];
	logic [`LSQ_DEPTH-1:0] flush_kill;
	logic [`LSQ_DEPTH-1:0] addr_valid_q;
	logic [`LSQ_DEPTH-1:0] data_ready_q;

	assign exe_op = op_table_i[exe_entry_i];
	assign exe_store = exe_op[2];

	// loads go to memory in the execute cycle, before the queue sees the address
	assign mem_load_en_o = exe_valid_i && !exe_store;
	assign mem_load_addr_o = exe_addr_i;
	assign mem_load_size_o = lsq_pkg::op_size(exe_op);

	lsq_field_ram #(
		.payload_t(lsq_pkg::addr_t)
	) i_addr_ram (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.wr_en_i  (exe_valid_i),
		.wr_idx_i (exe_entry_i),
		.wr_data_i(exe_addr_i),
		.entries_o(addr_table_o)
	);

	// one stage between execute and the data table, so a store's data and
	// a load reply never want the write port in the same cycle
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stage_store_q <= 1'b0;
		end else begin
			stage_store_q <= exe_valid_i && exe_store;
		end
	end

	// entry also steers the load reply that comes back next cycle
	always_ff @(posedge clk) begin
		if (exe_valid_i) begin
			stage_idx_q <= exe_entry_i;
			stage_data_q <= exe_data_i;
		end
	end

	assign data_wr_en = stage_store_q || mem_load_valid_i;
	assign data_wr_val = stage_store_q ? stage_data_q : mem_load_value_i;

	lsq_field_ram #(
		.payload_t(lsq_pkg::word_t)
	) i_data_ram (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.wr_en_i  (data_wr_en),
		.wr_idx_i (stage_idx_q),
		.wr_data_i(data_wr_val),
		.entries_o(data_ram)
	);

	// staged store data is visible at once, a commit may read it next cycle
	always_comb begin
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			data_table_o[i] = data_ram[i];
		end
		if (stage_store_q) begin
			data_table_o[stage_idx_q] = stage_data_q;
		end
	end

	always_comb begin
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			flush_kill[i] = flush_valid_i &&
				lsq_pkg::in_flush_range(lsq_pkg::index_t'(i), flush_entry_i, tail_i);
		end
	end

	// free or flushed entries drop their bits, this also covers committed ones
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			addr_valid_q <= '0;
			data_ready_q <= '0;
		end else begin
			for (int i = 0; i < `LSQ_DEPTH; i++) begin
				if (!occupied_i[i] || flush_kill[i]) begin
					addr_valid_q[i] <= 1'b0;
					data_ready_q[i] <= 1'b0;
				end else begin
					if (exe_valid_i && exe_entry_i == lsq_pkg::index_t'(i)) begin
						addr_valid_q[i] <= 1'b1;
					end
					if (mem_load_valid_i && stage_idx_q == lsq_pkg::index_t'(i)) begin
						data_ready_q[i] <= 1'b1;
					end
				end
			end
		end
	end

	assign addr_valid_o = addr_valid_q;
	assign data_ready_o = data_ready_q;

endmodule

// File: verilog/lsq_field_ram.sv
// per-entry register array for one queue field
// single write port, every entry visible at once for the searches
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_field_ram #(
	parameter type payload_t = logic [`LSQ_OPRAND_W-1:0]
) (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            wr_en_i,
	input  lsq_pkg::index_t wr_idx_i,
	input  payload_t        wr_data_i,
	output payload_t        entries_o [`LSQ_DEPTH]
);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `LSQ_DEPTH; i++) begin
				entries_o[i] <= payload_t'('0);
			end
		end else if (wr_en_i) begin
			entries_o[wr_idx_i] <= wr_data_i;
		end
	end

endmodule

// File: verilog/lsq_pkg.sv
// load/store queue shared types
// operation kinds, access sizes and the index, address and word types
`include "lsq_macros.svh"

package lsq_pkg;

	// top bit marks a store, low bits give the access size
	typedef enum logic [2:0] {
		LB = 3'b000,
		LH = 3'b001,
		LW = 3'b010,
		SB = 3'b100,
		SH = 3'b101,
		SW = 3'b110
	} ls_op_e;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} ls_size_e;

	typedef logic [`LSQ_INDEX_W-1:0] index_t;
	typedef logic [`LSQ_OPRAND_W-1:0] addr_t;
	typedef logic [`LSQ_OPRAND_W-1:0] word_t;

	function automatic ls_size_e op_size(ls_op_e op);
		case (op)
			LB, SB: return SIZE_BYTE;
			LH, SH: return SIZE_HALF;
			default: return SIZE_WORD;
		endcase
	endfunction

	function automatic logic [2:0] size_bytes(ls_size_e size);
		case (size)
			SIZE_BYTE: return 3'd1;
			SIZE_HALF: return 3'd2;
			default: return 3'(`LSQ_OPRAND_W / `LSQ_BYTE_W);
		endcase
	endfunction

	// true when idx lies in [first, tail) going around the ring
	function automatic logic in_flush_range(index_t idx, index_t first, index_t tail);
		return index_t'(idx - first) < index_t'(tail - first);
	endfunction

endpackage

// File: verilog/lsq_result.sv
// commit side of the load/store queue
// retires the head entry to the load output or the memory store port
// and searches younger loads that a committing store overlaps
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_result (
	input  logic                  commit_i,
	input  lsq_pkg::index_t       head_i,
	input  lsq_pkg::index_t       tail_i,
	input  logic [`LSQ_DEPTH-1:0] occupied_i,
	input  lsq_pkg::ls_op_e       op_table_i [`LSQ_DEPTH],
	input  lsq_pkg::addr_t        addr_table_i [`LSQ_DEPTH],
	input  lsq_pkg::word_t        data_table_i [`LSQ_DEPTH],
	input  logic [`LSQ_DEPTH-1:0] addr_valid_i,
	input  logic [`LSQ_DEPTH-1:0] data_ready_i,
	output logic                  load_valid_o,
	output lsq_pkg::word_t        load_data_o,
	output logic                  mem_store_en_o,
	output lsq_pkg::addr_t        mem_store_addr_o,
	output lsq_pkg::ls_size_e     mem_store_size_o,
	output lsq_pkg::word_t        mem_store_data_o,
	output logic                  commit_adv_o,
	output logic                  flush_valid_o,
	output lsq_pkg::index_t       flush_entry_o
);

	lsq_pkg::ls_op_e head_op;
	logic head_store;
	logic head_ready;
	logic commit_ok;
	logic [`LSQ_OPRAND_W:0] st_lo;
	logic [`LSQ_OPRAND_W:0] st_hi;
	logic [`LSQ_DEPTH-1:0] overlap;
	logic hit;
	lsq_pkg::index_t hit_idx;

	assign head_op = op_table_i[head_i];
	assign head_store = head_op[2];

	// store is ready with its address, load once its reply is in
	assign head_ready = occupied_i[head_i] &&
		(head_store ? addr_valid_i[head_i] : data_ready_i[head_i]);
	assign commit_ok = commit_i && head_ready;
	assign commit_adv_o = commit_ok;

	assign load_valid_o = commit_ok && !head_store;
	assign load_data_o = data_table_i[head_i];

	assign mem_store_en_o = commit_ok && head_store;
	assign mem_store_addr_o = addr_table_i[head_i];
	assign mem_store_size_o = lsq_pkg::op_size(head_op);
	assign mem_store_data_o = data_table_i[head_i];

	// byte ranges kept one bit wider so the end never wraps
	assign st_lo = {1'b0, mem_store_addr_o};
	assign st_hi = st_lo + lsq_pkg::size_bytes(mem_store_size_o) - 1'b1;

	always_comb begin
		logic [`LSQ_OPRAND_W:0] ld_lo;
		logic [`LSQ_OPRAND_W:0] ld_hi;
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			ld_lo = {1'b0, addr_table_i[i]};
			ld_hi = ld_lo + lsq_pkg::size_bytes(lsq_pkg::op_size(op_table_i[i])) - 1'b1;
			overlap[i] = (ld_lo <= st_hi) && (st_lo <= ld_hi);
		end
	end

	// walk from head+1 in age order, stop at the tail, first match is oldest
	always_comb begin
		lsq_pkg::index_t idx;
		logic live;
		hit = 1'b0;
		hit_idx = '0;
		live = 1'b1;
		for (int k = 1; k < `LSQ_DEPTH; k++) begin
			idx = head_i + lsq_pkg::index_t'(k);
			if (idx == tail_i) begin
				live = 1'b0;
			end
			if (live && !hit && addr_valid_i[idx] && !op_table_i[idx][2] && overlap[idx]) begin
				hit = 1'b1;
				hit_idx = idx;
			end
		end
	end

	assign flush_valid_o = mem_store_en_o && hit;
	assign flush_entry_o = hit_idx;

endmodule

// File: verilog/lsq_top.sv
// load/store queue top level
// dispatch, execute and commit stages around shared entry tables
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_top (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                enq_valid_i,
	input  lsq_pkg::ls_op_e     enq_op_i,
	output lsq_pkg::index_t     enq_entry_o,
	output logic                full_o,
	input  logic                exe_valid_i,
	input  lsq_pkg::index_t     exe_entry_i,
	input  lsq_pkg::addr_t      exe_addr_i,
	input  lsq_pkg::word_t      exe_data_i,
	output logic                mem_load_en_o,
	output lsq_pkg::addr_t      mem_load_addr_o,
	output lsq_pkg::ls_size_e   mem_load_size_o,
	input  logic                mem_load_valid_i,
	input  lsq_pkg::word_t      mem_load_value_i,
	output logic                mem_store_en_o,
	output lsq_pkg::addr_t      mem_store_addr_o,
	output lsq_pkg::ls_size_e   mem_store_size_o,
	output lsq_pkg::word_t      mem_store_data_o,
	input  logic                commit_i,
	output logic                load_valid_o,
	output lsq_pkg::word_t      load_data_o,
	output logic                flush_valid_o,
	output lsq_pkg::index_t     flush_entry_o
);

	lsq_pkg::index_t head;
	lsq_pkg::index_t tail;
	logic [`LSQ_DEPTH-1:0] occupied;
	lsq_pkg::ls_op_e op_table [`LSQ_DEPTH];
	lsq_pkg::addr_t addr_table [`LSQ_DEPTH];
	lsq_pkg::word_t data_table [`LSQ_DEPTH];
	logic [`LSQ_DEPTH-1:0] addr_valid;
	logic [`LSQ_DEPTH-1:0] data_ready;
	logic commit_adv;

	lsq_decode i_decode (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.enq_valid_i  (enq_valid_i),
		.enq_op_i     (enq_op_i),
		.commit_adv_i (commit_adv),
		.flush_valid_i(flush_valid_o),
		.flush_entry_i(flush_entry_o),
		.enq_entry_o  (enq_entry_o),
		.full_o       (full_o),
		.head_o       (head),
		.tail_o       (tail),
		.occupied_o   (occupied),
		.op_table_o   (op_table)
	);

	lsq_execute i_execute (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.exe_valid_i     (exe_valid_i),
		.exe_entry_i     (exe_entry_i),
		.exe_addr_i      (exe_addr_i),
		.exe_data_i      (exe_data_i),
		.op_table_i      (op_table),
		.occupied_i      (occupied),
		.mem_load_valid_i(mem_load_valid_i),
		.mem_load_value_i(mem_load_value_i),
		.flush_valid_i   (flush_valid_o),
		.flush_entry_i   (flush_entry_o),
		.tail_i          (tail),
		.mem_load_en_o   (mem_load_en_o),
		.mem_load_addr_o (mem_load_addr_o),
		.mem_load_size_o (mem_load_size_o),
		.addr_table_o    (addr_table),
		.data_table_o    (data_table),
		.addr_valid_o    (addr_valid),
		.data_ready_o    (data_ready)
	);

	lsq_result i_result (
		.commit_i        (commit_i),
		.head_i          (head),
		.tail_i          (tail),
		.occupied_i      (occupied),
		.op_table_i      (op_table),
		.addr_table_i    (addr_table),
		.data_table_i    (data_table),
		.addr_valid_i    (addr_valid),
		.data_ready_i    (data_ready),
		.load_valid_o    (load_valid_o),
		.load_data_o     (load_data_o),
		.mem_store_en_o  (mem_store_en_o),
		.mem_store_addr_o(mem_store_addr_o),
		.mem_store_size_o(mem_store_size_o),
		.mem_store_data_o(mem_store_data_o),
		.commit_adv_o    (commit_adv),
		.flush_valid_o   (flush_valid_o),
		.flush_entry_o   (flush_entry_o)
	);

endmodule
